// ==== hw/conv_in_params.svh ====
// geometry and constants of the convolution input line cache
// the sequencer has fixed row states, so CONV_ROWS stays at 3
// CONV_LANES must not exceed CONV_ROW_PIXELS
`ifndef CONV_IN_PARAMS_SVH
`define CONV_IN_PARAMS_SVH

// one pixel is an IEEE 754 single
`define CONV_PIX_WIDTH 32

// cached image rows, eight pixels each
`define CONV_ROW_PIXELS 8
`define CONV_ROWS 3

// kernel lanes taken from the left of the window
`define CONV_LANES 6
`define CONV_SHIFTS 3

`define CONV_ADDR_WIDTH 8

// bias beat value, float 1.0
`define CONV_FLOAT_ONE 32'h3F800000

`endif

// ==== hw/conv_in_pkg.sv ====
// types shared by the line cache sequencer, banks and window
// row_t index 0 is the leftmost pixel
// row_set_t index 0 is the oldest row
`include "conv_in_params.svh"

package conv_in_pkg;

	typedef logic [`CONV_PIX_WIDTH-1:0] pixel_t;

	typedef enum logic [1:0] {
		CMD_NONE    = 2'd0,
		CMD_PRELOAD = 2'd1,
		CMD_SHIFT   = 2'd2,
		CMD_LOAD    = 2'd3
	} cmd_t;

	typedef enum logic [1:0] {
		ACK_NONE         = 2'd0,
		ACK_PRELOAD_DONE = 2'd1,
		ACK_SHIFT_DONE   = 2'd2,
		ACK_LOAD_DONE    = 2'd3
	} ack_t;

	// row states are consecutive, the sequencer steps through them by +1
	typedef enum logic [2:0] {
		ST_IDLE    = 3'd0,
		ST_PRELOAD = 3'd1,
		ST_ROW0    = 3'd2,
		ST_ROW1    = 3'd3,
		ST_ROW2    = 3'd4,
		ST_BIAS    = 3'd5,
		ST_LOAD    = 3'd6
	} state_t;

	typedef pixel_t [`CONV_ROW_PIXELS-1:0] row_t;
	typedef row_t [`CONV_ROWS-1:0] row_set_t;

	typedef struct packed {
		logic write;
		logic roll;
		logic [$clog2(`CONV_ROW_PIXELS)-1:0] slot;
	} bank_op_t;

	typedef struct packed {
		logic load;
		logic shift;
		logic bias;
		logic clear;
		logic [$clog2(`CONV_ROWS)-1:0] row_sel;
	} win_op_t;

	typedef struct packed {
		logic valid;
		logic bias;
		pixel_t [`CONV_LANES-1:0] lanes;
	} window_t;

endpackage

// ==== hw/conv_in_ctrl.sv ====
// sequencer of the line cache
// commands are taken only in idle with enable high, others are dropped
// pixel memory is combinational: pixel_in must match rom_addr in the same cycle
// bank_op and win_op are registered, the data blocks act one edge later
`timescale 1ns/1ps
`include "conv_in_params.svh"

module conv_in_ctrl (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        enable,
	input  conv_in_pkg::cmd_t           cmd,
	output conv_in_pkg::ack_t           ack,
	output logic [`CONV_ADDR_WIDTH-1:0] rom_addr,
	output conv_in_pkg::bank_op_t       bank_op,
	output conv_in_pkg::win_op_t        win_op
);
	import conv_in_pkg::*;

	localparam int SLOT_W = $clog2(`CONV_ROW_PIXELS);
	localparam int ROW_W = $clog2(`CONV_ROWS);
	localparam int RCNT_W = $clog2(`CONV_ROWS + 1);
	localparam int OFF_W = $clog2(`CONV_SHIFTS);

	state_t state;
	state_t state_d;
	ack_t ack_d;
	bank_op_t bank_op_d;
	bank_op_t fill_op;
	win_op_t win_op_d;
	win_op_t step_op;
	logic [SLOT_W-1:0] slot_cnt;
	logic [SLOT_W-1:0] slot_d;
	logic [RCNT_W-1:0] row_cnt;
	logic [RCNT_W-1:0] row_cnt_d;
	logic [OFF_W-1:0] off_cnt;
	logic [OFF_W-1:0] off_d;
	logic [ROW_W-1:0] cur_row;
	logic slot_last;
	logic off_last;
	logic addr_clr;

	assign slot_last = (slot_cnt == SLOT_W'(`CONV_ROW_PIXELS - 1));
	assign off_last = (off_cnt == OFF_W'(`CONV_SHIFTS - 1));

	// one pixel fetch, banks roll on slot 0
	assign fill_op = '{write: 1'b1, roll: (slot_cnt == '0), slot: slot_cnt};

	always_comb begin
		case (state)
			ST_ROW1: cur_row = ROW_W'(1);
			ST_ROW2: cur_row = ROW_W'(2);
			default: cur_row = '0;
		endcase
	end

	// row load on offset 0 then left shifts
	assign step_op = '{load: (off_cnt == '0), shift: (off_cnt != '0), bias: 1'b0,
		clear: 1'b0, row_sel: cur_row};

	always_comb begin
		state_d = state;
		ack_d = ACK_NONE;
		bank_op_d = '0;
		win_op_d = '0;
		row_cnt_d = row_cnt;
		addr_clr = 1'b0;
		case (state)
			ST_IDLE: begin
				case (cmd)
					CMD_PRELOAD: begin
						state_d = ST_PRELOAD;
						addr_clr = 1'b1;
						bank_op_d = fill_op;
					end
					CMD_LOAD: begin
						state_d = ST_LOAD;
						bank_op_d = fill_op;
					end
					CMD_SHIFT: begin
						state_d = ST_ROW0;
						win_op_d = step_op;
					end
					default: ;
				endcase
			end
			ST_PRELOAD: begin
				if (row_cnt == RCNT_W'(`CONV_ROWS)) begin
					ack_d = ACK_PRELOAD_DONE;
					state_d = ST_IDLE;
					row_cnt_d = '0;
				end else begin
					bank_op_d = fill_op;
					if (slot_last) begin
						row_cnt_d = row_cnt + 1'b1;
					end
				end
			end
			ST_LOAD: begin
				// slot wrapped back to 0 after the last fetch
				if (slot_cnt == '0) begin
					ack_d = ACK_LOAD_DONE;
					state_d = ST_IDLE;
				end else begin
					bank_op_d = fill_op;
				end
			end
			ST_ROW0, ST_ROW1, ST_ROW2: begin
				win_op_d = step_op;
				if (off_last) begin
					state_d = state_t'(state + 3'd1);
				end
			end
			ST_BIAS: begin
				// two beats: bias fill, then clear with the ack
				if (off_cnt == '0) begin
					win_op_d.bias = 1'b1;
				end else begin
					win_op_d.clear = 1'b1;
					ack_d = ACK_SHIFT_DONE;
					state_d = ST_IDLE;
				end
			end
			default: state_d = ST_IDLE;
		endcase
	end

	assign slot_d = !bank_op_d.write ? slot_cnt : (slot_last ? '0 : slot_cnt + 1'b1);

	always_comb begin
		off_d = off_cnt;
		if (win_op_d.clear) begin
			off_d = '0;
		end else if (win_op_d != '0) begin
			off_d = off_last ? '0 : off_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			ack <= ACK_NONE;
			bank_op <= '0;
			win_op <= '0;
			slot_cnt <= '0;
			row_cnt <= '0;
			off_cnt <= '0;
			rom_addr <= '0;
		end else if (enable) begin
			state <= state_d;
			ack <= ack_d;
			bank_op <= bank_op_d;
			win_op <= win_op_d;
			slot_cnt <= slot_d;
			row_cnt <= row_cnt_d;
			off_cnt <= off_d;
			// address moves on with every pixel the banks take
			if (addr_clr) begin
				rom_addr <= '0;
			end else if (bank_op.write) begin
				rom_addr <= rom_addr + 1'b1;
			end
		end
	end

endmodule

// ==== hw/row_bank.sv ====
// three cached image rows of pixel registers
// new pixels always land in the newest row
// a roll and a write in the same cycle both take effect
// slot is not range checked here
`timescale 1ns/1ps
`include "conv_in_params.svh"

module row_bank (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   enable,
	input  conv_in_pkg::bank_op_t  bank_op,
	input  conv_in_pkg::pixel_t    pixel_in,
	output conv_in_pkg::row_set_t  rows
);
	import conv_in_pkg::*;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rows <= '0;
		end else if (enable) begin
			// oldest row drops out, the rest move up one bank
			if (bank_op.roll) begin
				for (int i = 0; i < `CONV_ROWS - 1; i++) begin
					rows[i] <= rows[i+1];
				end
			end
			// newest row keeps its stale pixels until rewritten
			if (bank_op.write) begin
				rows[`CONV_ROWS-1][bank_op.slot] <= pixel_in;
			end
		end
	end

endmodule

// ==== hw/window_shifter.sv ====
// kernel window in front of the multiply lanes
// ops are applied in order clear, bias, load, shift
// only the leftmost CONV_LANES pixels reach the lanes
`timescale 1ns/1ps
`include "conv_in_params.svh"

module window_shifter (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   enable,
	input  conv_in_pkg::win_op_t   win_op,
	input  conv_in_pkg::row_set_t  rows,
	output conv_in_pkg::window_t   window
);
	import conv_in_pkg::*;

	row_t pix;
	logic valid_q;
	logic bias_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pix <= '0;
			valid_q <= 1'b0;
			bias_q <= 1'b0;
		end else if (enable) begin
			if (win_op.clear) begin
				pix <= '0;
				valid_q <= 1'b0;
				bias_q <= 1'b0;
			end else if (win_op.bias) begin
				// bias beat carries no pixel data
				pix <= {`CONV_ROW_PIXELS{pixel_t'(`CONV_FLOAT_ONE)}};
				valid_q <= 1'b0;
				bias_q <= 1'b1;
			end else if (win_op.load) begin
				pix <= rows[win_op.row_sel];
				valid_q <= 1'b1;
				bias_q <= 1'b0;
			end else if (win_op.shift) begin
				// one pixel towards lane 0
				// zero fills from the right
				pix <= {pixel_t'(0), pix[`CONV_ROW_PIXELS-1:1]};
				valid_q <= 1'b1;
				bias_q <= 1'b0;
			end
		end
	end

	assign window = '{valid: valid_q, bias: bias_q, lanes: pix[`CONV_LANES-1:0]};

endmodule

// ==== hw/conv_in_top.sv ====
// line cache between pixel memory and the convolution lanes
// pixel memory must answer rom_addr combinationally on pixel_in
// enable low freezes every register, ack and window included
`timescale 1ns/1ps
`include "conv_in_params.svh"

module conv_in_top (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        enable,
	input  conv_in_pkg::cmd_t           cmd,
	input  conv_in_pkg::pixel_t         pixel_in,
	output conv_in_pkg::ack_t           ack,
	output logic [`CONV_ADDR_WIDTH-1:0] rom_addr,
	output conv_in_pkg::window_t        window
);
	import conv_in_pkg::*;

	bank_op_t bank_op;
	win_op_t win_op;
	row_set_t rows;

	conv_in_ctrl u_ctrl (
		.clk      (clk),
		.rst_n    (rst_n),
		.enable   (enable),
		.cmd      (cmd),
		.ack      (ack),
		.rom_addr (rom_addr),
		.bank_op  (bank_op),
		.win_op   (win_op)
	);

	row_bank u_bank (
		.clk      (clk),
		.rst_n    (rst_n),
		.enable   (enable),
		.bank_op  (bank_op),
		.pixel_in (pixel_in),
		.rows     (rows)
	);

	window_shifter u_win (
		.clk    (clk),
		.rst_n  (rst_n),
		.enable (enable),
		.win_op (win_op),
		.rows   (rows),
		.window (window)
	);

endmodule

// ==== dv/conv_in_chk.sv ====
// protocol assertions for the line cache top level
// attached by bind, reaches the sequencer state through u_ctrl
`timescale 1ns/1ps
`include "conv_in_params.svh"

module conv_in_chk (
	input logic                        clk,
	input logic                        rst_n,
	input logic                        enable,
	input conv_in_pkg::cmd_t           cmd,
	input conv_in_pkg::ack_t           ack,
	input logic [`CONV_ADDR_WIDTH-1:0] rom_addr,
	input conv_in_pkg::window_t        window,
	input conv_in_pkg::state_t         state
);
	import conv_in_pkg::*;

	// a done code is gone after one enabled edge
	ack_one_beat: assert property (@(posedge clk) disable iff (!rst_n)
		(ack != ACK_NONE && enable) |=> (ack == ACK_NONE))
		else $error("ack code held longer than one enabled cycle");

	bias_beat_shape: assert property (@(posedge clk) disable iff (!rst_n)
		window.bias |-> (window.lanes == {`CONV_LANES{pixel_t'(`CONV_FLOAT_ONE)}}
			&& ack == ACK_SHIFT_DONE))
		else $error("bias beat without float one lanes or shift done ack");

	stall_freeze: assert property (@(posedge clk) disable iff (!rst_n)
		!enable |=> ($stable(ack) && $stable(rom_addr) && $stable(window)))
		else $error("outputs moved while enable was low");

	// preload clears the address at its accepting edge, still in idle
	addr_only_in_fetch: assert property (@(posedge clk) disable iff (!rst_n)
		(state != ST_PRELOAD && state != ST_LOAD
			&& !(state == ST_IDLE && cmd == CMD_PRELOAD)) |=> $stable(rom_addr))
		else $error("rom_addr changed outside a fetch operation");

endmodule

bind conv_in_top conv_in_chk u_chk (
	.clk      (clk),
	.rst_n    (rst_n),
	.enable   (enable),
	.cmd      (cmd),
	.ack      (ack),
	.rom_addr (rom_addr),
	.window   (window),
	.state    (u_ctrl.state)
);

// ==== dv/conv_in_tb.sv ====
// self-checking testbench for the line cache
// the ROM model answers rom_addr on each falling edge, ahead of the bank write
// expected lanes come from a three-row model fed from the same ROM
// the run is cut off after MAX_CYCLES clock cycles
`timescale 1ns/1ps
`include "conv_in_params.svh"

module conv_in_tb;
	import conv_in_pkg::*;

	// about 120 cycles of tests, kept well clear of the limit
	localparam int MAX_CYCLES = 400;

	logic clk;
	logic rst_n;
	logic enable;
	cmd_t cmd;
	pixel_t pixel_in;
	ack_t ack;
	logic [`CONV_ADDR_WIDTH-1:0] rom_addr;
	window_t window;

	pixel_t rom [0:(1 << `CONV_ADDR_WIDTH)-1];
	pixel_t model_rows [`CONV_ROWS][`CONV_ROW_PIXELS];
	logic [`CONV_ADDR_WIDTH-1:0] model_addr;
	logic [31:0] seed;
	string cur_test;
	int test_errs;
	int tests_run;
	int tests_failed;
	int cycles;

	conv_in_top UUT (
		.clk      (clk),
		.rst_n    (rst_n),
		.enable   (enable),
		.cmd      (cmd),
		.pixel_in (pixel_in),
		.ack      (ack),
		.rom_addr (rom_addr),
		.window   (window)
	);

	always #50 clk = ~clk;

	always @(negedge clk) begin
		pixel_in = rom[rom_addr];
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("=== FAIL ===");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic expect_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp) else begin
			$display("Fail %s %s: expected %h, actual %h", cur_test, what, exp, act);
			test_errs++;
		end
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		test_errs = 0;
	endtask

	task automatic end_test();
		tests_run++;
		if (test_errs == 0) begin
			$display("test %s: ok", cur_test);
		end else begin
			$display("test %s: %0d errors", cur_test, test_errs);
			tests_failed++;
		end
	endtask

	// oldest row drops, next eight ROM words become the newest row
	task automatic model_row_load();
		for (int r = 0; r < `CONV_ROWS - 1; r++) begin
			for (int k = 0; k < `CONV_ROW_PIXELS; k++) begin
				model_rows[r][k] = model_rows[r+1][k];
			end
		end
		for (int k = 0; k < `CONV_ROW_PIXELS; k++) begin
			model_rows[`CONV_ROWS-1][k] = rom[model_addr];
			model_addr = model_addr + 1'b1;
		end
	endtask

	// called on a falling edge, DUT idle
	task automatic issue_cmd(input cmd_t c);
		cmd = c;
		@(negedge clk);
		cmd = CMD_NONE;
	endtask

	task automatic wait_ack();
		while (ack == ACK_NONE) begin
			@(negedge clk);
		end
	endtask

	// stall_beat < 0 runs without a stall
	task automatic run_shift(input int stall_beat);
		window_t held;
		issue_cmd(CMD_SHIFT);
		// first window is due one edge after the accepting edge
		@(negedge clk);
		for (int b = 0; b < `CONV_ROWS * `CONV_SHIFTS; b++) begin
			expect_eq($sformatf("beat %0d valid", b), 32'd1, 32'(window.valid));
			for (int j = 0; j < `CONV_LANES; j++) begin
				expect_eq($sformatf("beat %0d lane %0d", b, j),
					model_rows[b / `CONV_SHIFTS][b % `CONV_SHIFTS + j], window.lanes[j]);
			end
			if (b == stall_beat) begin
				held = window;
				enable = 1'b0;
				repeat (4) begin
					@(negedge clk);
					assert (window == held && ack == ACK_NONE) else begin
						$display("%s: window or ack moved while enable was low", cur_test);
						test_errs++;
					end
				end
				enable = 1'b1;
			end
			@(negedge clk);
		end
		expect_eq("bias flag", 32'd1, 32'(window.bias));
		expect_eq("bias valid", 32'd0, 32'(window.valid));
		expect_eq("bias ack", 32'(ACK_SHIFT_DONE), 32'(ack));
		for (int j = 0; j < `CONV_LANES; j++) begin
			expect_eq($sformatf("bias lane %0d", j), `CONV_FLOAT_ONE, window.lanes[j]);
		end
		@(negedge clk);
		expect_eq("cleared flags", 32'd0, {30'd0, window.valid, window.bias});
		for (int j = 0; j < `CONV_LANES; j++) begin
			expect_eq($sformatf("cleared lane %0d", j), 32'd0, window.lanes[j]);
		end
		expect_eq("ack after bias", 32'(ACK_NONE), 32'(ack));
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		enable = 1'b1;
		cmd = CMD_NONE;
		pixel_in = '0;
		cycles = 0;
		tests_run = 0;
		tests_failed = 0;
		model_addr = '0;
		seed = 32'hdb15_f80f;
		for (int i = 0; i < (1 << `CONV_ADDR_WIDTH); i++) begin
			seed = xorshift32(seed);
			rom[i] = seed;
		end
		repeat (3) @(negedge clk);
		rst_n = 1'b1;

		start_test("reset_values");
		expect_eq("ack", 32'(ACK_NONE), 32'(ack));
		expect_eq("rom_addr", 32'd0, 32'(rom_addr));
		expect_eq("valid and bias", 32'd0, {30'd0, window.valid, window.bias});
		end_test();

		start_test("preload");
		issue_cmd(CMD_PRELOAD);
		wait_ack();
		expect_eq("ack", 32'(ACK_PRELOAD_DONE), 32'(ack));
		expect_eq("rom_addr", 32'd24, 32'(rom_addr));
		repeat (`CONV_ROWS) model_row_load();
		@(negedge clk);
		expect_eq("ack one beat", 32'(ACK_NONE), 32'(ack));
		end_test();

		start_test("shift_after_preload");
		run_shift(-1);
		end_test();

		start_test("load_roll_stall");
		issue_cmd(CMD_LOAD);
		wait_ack();
		expect_eq("ack", 32'(ACK_LOAD_DONE), 32'(ack));
		expect_eq("rom_addr", 32'd32, 32'(rom_addr));
		model_row_load();
		@(negedge clk);
		run_shift(4);
		end_test();

		// a preload slipped into a running load must leave no trace
		start_test("ignored_cmd");
		issue_cmd(CMD_LOAD);
		@(negedge clk);
		issue_cmd(CMD_PRELOAD);
		wait_ack();
		expect_eq("ack", 32'(ACK_LOAD_DONE), 32'(ack));
		model_row_load();
		repeat (30) begin
			@(negedge clk);
			assert (ack == ACK_NONE) else begin
				$display("%s: extra ack after a command given while busy", cur_test);
				test_errs++;
			end
		end
		expect_eq("rom_addr", 32'd40, 32'(rom_addr));
		end_test();

		$display("tests run %0d, passed %0d, failed %0d",
			tests_run, tests_run - tests_failed, tests_failed);
		if (tests_failed == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// ==== filelist.f ====
+incdir+hw
hw/conv_in_pkg.sv
hw/conv_in_ctrl.sv
hw/row_bank.sv
hw/window_shifter.sv
hw/conv_in_top.sv
dv/conv_in_chk.sv
dv/conv_in_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert -f filelist.f \
		--top-module conv_in_tb -o sim_conv_in \
	&& ./obj_dir/sim_conv_in | tee /dev/stderr | grep -x '=== PASS ===' > /dev/null \
	&& echo "run.sh: simulation passed" \
	|| { echo "run.sh: simulation failed"; exit 1; }
